//--- src/cab_cfg.svh
//////////////////////////////////////////////////////////////////////
// Cabinet shell configuration
// Fixed widths shared by the host link, combiner and top level
//////////////////////////////////////////////////////////////////////

`ifndef CAB_CFG_SVH
`define CAB_CFG_SVH

// Host data word, also the width of status and joystick words
`define CAB_HOST_DW 16

// Core audio sample width and widened output sample width
`define CAB_AUDIO_IN_W 4
`define CAB_AUDIO_OUT_W 16

`endif

//--- src/cab_pkg.sv
//////////////////////////////////////////////////////////////////////
// Cabinet shell package
// Host opcode and handshake state types
//////////////////////////////////////////////////////////////////////

package cab_pkg;

	// Word selector sent with each host transfer
	typedef enum logic [1:0] {
		OP_STATUS = 2'd0,
		OP_JOY0   = 2'd1,
		OP_JOY1   = 2'd2,
		OP_NOP    = 2'd3
	} host_op_e;

	// Four-phase handshake states of the host link
	typedef enum logic [1:0] {
		LINK_IDLE      = 2'd0,
		LINK_ACK       = 2'd1,
		LINK_WAIT_DROP = 2'd2
	} link_state_e;

endpackage

//--- src/cab_regs_if.sv
//////////////////////////////////////////////////////////////////////
// Stored host words interface
// Carries the link's registered words to the decoding blocks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "cab_cfg.svh"

interface cab_regs_if;

	// Both joystick words merged by OR
	logic [`CAB_HOST_DW-1:0] joy;
	// Menu status word
	logic [`CAB_HOST_DW-1:0] status;
	// ROM download flag, already synchronized
	logic                    download;
	// Single-cycle strobe when a word lands
	logic                    upd;

	modport link   (output joy, output status, output download, output upd);
	modport mapper (input joy, input upd);
	modport menu   (input status, input download, input upd);

endinterface

//--- src/host_link.sv
//////////////////////////////////////////////////////////////////////
// Host link
// Four-phase req/ack receiver storing status and joystick words
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "cab_cfg.svh"

module host_link import cab_pkg::*; (
	input  logic                    clk_50,
	input  logic                    arst_n,
	input  logic                    host_req,
	input  host_op_e                host_op,
	input  logic [`CAB_HOST_DW-1:0] host_data,
	input  logic                    download_in,
	output logic                    host_ack,
	cab_regs_if.link                regs
);

	// Two-flop synchronizers for req and download
	logic [1:0] req_sync;
	logic [1:0] dl_sync;
	logic       req_s;

	link_state_e state_q;
	link_state_e state_d;

	// Stored words
	logic [`CAB_HOST_DW-1:0] status_q;
	logic [`CAB_HOST_DW-1:0] joy0_q;
	logic [`CAB_HOST_DW-1:0] joy1_q;
	logic                    upd_q;
	logic                    take;

	always_ff @(posedge clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			req_sync <= 2'b00;
			dl_sync  <= 2'b00;
		end else begin
			req_sync <= {req_sync[0], host_req};
			dl_sync  <= {dl_sync[0], download_in};
		end
	end

	assign req_s = req_sync[1];

	//////////////////////////////////////////////////////////////////////
	// Handshake FSM
	//////////////////////////////////////////////////////////////////////

	// ACK lasts one cycle on entry, WAIT_DROP holds ack until req falls
	always_comb begin
		state_d = state_q;
		case (state_q)
			LINK_IDLE:      if (req_s) state_d = LINK_ACK;
			LINK_ACK:       state_d = req_s ? LINK_WAIT_DROP : LINK_IDLE;
			LINK_WAIT_DROP: if (!req_s) state_d = LINK_IDLE;
			default:        state_d = LINK_IDLE;
		endcase
	end

	always_ff @(posedge clk_50 or negedge arst_n) begin
		if (!arst_n) state_q <= LINK_IDLE;
		else         state_q <= state_d;
	end

	// Ack is high in every state except idle
	assign host_ack = (state_q != LINK_IDLE);

	// Word capture happens on the edge that enters LINK_ACK
	assign take = (state_q == LINK_IDLE) && req_s;

	always_ff @(posedge clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			status_q <= '0;
			joy0_q   <= '0;
			joy1_q   <= '0;
			upd_q    <= 1'b0;
		end else begin
			upd_q <= 1'b0;
			if (take) begin
				case (host_op)
					OP_STATUS: begin status_q <= host_data; upd_q <= 1'b1; end
					OP_JOY0:   begin joy0_q <= host_data; upd_q <= 1'b1; end
					OP_JOY1:   begin joy1_q <= host_data; upd_q <= 1'b1; end
					default:   upd_q <= 1'b0;
				endcase
			end
		end
	end

	// Publish to the decoding blocks
	assign regs.joy      = joy0_q | joy1_q;
	assign regs.status   = status_q;
	assign regs.download = dl_sync[1];
	assign regs.upd      = upd_q;

endmodule

//--- src/tread_mapper.sv
//////////////////////////////////////////////////////////////////////
// Tread mapper
// Converts the merged joystick into the two-tread control byte
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tread_mapper import cab_pkg::*; (
	input  logic       clk_50,
	input  logic       arst_n,
	cab_regs_if.mapper regs,
	output logic [7:0] ctrl_byte
);

	// Direction nibble, up down left right
	logic [3:0] dir;
	// Tread bits, left fwd, left back, right fwd, right back
	logic [3:0] tread;
	// Button bits, coin, start 2P, start 1P, fire
	logic [3:0] btn;

	assign dir = regs.joy[3:0];
	assign btn = {regs.joy[7], regs.joy[5], regs.joy[6], regs.joy[4]};

	//////////////////////////////////////////////////////////////////////
	// Direction table
	//////////////////////////////////////////////////////////////////////

	// Diagonals stop one tread, straight moves drive both
	always_comb begin
		case (dir)
			// Up, both forward
			4'b1000: tread = 4'b1010;
			// Up-left, right tread only
			4'b1010: tread = 4'b0010;
			// Up-right, left tread only
			4'b1001: tread = 4'b1000;
			// Right, spin clockwise
			4'b0001: tread = 4'b1001;
			// Down-right
			4'b0101: tread = 4'b0100;
			// Down, both back
			4'b0100: tread = 4'b0101;
			// Down-left
			4'b0110: tread = 4'b0001;
			// Left, spin counterclockwise
			4'b0010: tread = 4'b0110;
			// Idle or conflicting directions
			default: tread = 4'b0000;
		endcase
	end

	// Reload only when the link has stored a new word
	always_ff @(posedge clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_byte <= 8'h00;
		end else if (regs.upd) begin
			ctrl_byte <= {btn, tread};
		end
	end

endmodule

//--- src/menu_decoder.sv
//////////////////////////////////////////////////////////////////////
// Menu decoder
// Splits the status word into aspect, DIP switches and reset request
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module menu_decoder import cab_pkg::*; (
	input  logic       clk_50,
	input  logic       arst_n,
	cab_regs_if.menu   regs,
	output logic [1:0] aspect_sel,
	output logic [7:0] dsw,
	output logic       reset_req
);

	// Status bit map
	// 15:14 aspect ratio select
	// 13:6  DIP switch byte
	// 0     menu reset

	// Menu fields follow the status word on each store
	always_ff @(posedge clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			aspect_sel <= 2'b00;
			dsw        <= 8'h00;
		end else if (regs.upd) begin
			aspect_sel <= regs.status[15:14];
			dsw        <= regs.status[13:6];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reset request
	//////////////////////////////////////////////////////////////////////

	// Download toggles on its own so this path is sampled every cycle
	always_ff @(posedge clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			reset_req <= 1'b0;
		end else begin
			reset_req <= regs.status[0] | regs.download;
		end
	end

endmodule

//--- src/cabinet_combiner.sv
//////////////////////////////////////////////////////////////////////
// Cabinet combiner
// Core reset, gated controls, aspect, pixel enable and audio widening
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "cab_cfg.svh"

module cabinet_combiner import cab_pkg::*; (
	input  logic                        clk_50,
	input  logic                        arst_n,
	input  logic                        rst_in,
	input  logic [7:0]                  ctrl_byte,
	input  logic [1:0]                  aspect_sel,
	input  logic                        reset_req,
	input  logic [`CAB_AUDIO_IN_W-1:0]  audio_in,
	output logic                        core_reset,
	output logic [7:0]                  jb,
	output logic [11:0]                 video_arx,
	output logic [11:0]                 video_ary,
	output logic                        ce_pix,
	output logic [`CAB_AUDIO_OUT_W-1:0] audio_l
);

	// External reset stage, lines up with the decoder's reset_req
	logic rst_q;
	logic core_reset_d;
	// Audio input stage, same depth as the external reset path
	logic [`CAB_AUDIO_IN_W-1:0] audio_q;

	assign core_reset_d = rst_q | reset_req;

	always_ff @(posedge clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			rst_q      <= 1'b1;
			core_reset <= 1'b1;
			jb         <= 8'h00;
			video_arx  <= 12'd4;
			video_ary  <= 12'd3;
			ce_pix     <= 1'b0;
		end else begin
			rst_q      <= rst_in;
			core_reset <= core_reset_d;
			// Controls held off for as long as the core is in reset
			jb         <= core_reset_d ? 8'h00 : ctrl_byte;
			// Select 0 is the original 4:3, others pass an ARC index
			if (aspect_sel == 2'b00) begin
				video_arx <= 12'd4;
				video_ary <= 12'd3;
			end else begin
				video_arx <= {10'd0, aspect_sel - 2'd1};
				video_ary <= 12'd0;
			end
			// Half-rate pixel enable
			ce_pix     <= ~ce_pix;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Audio
	//////////////////////////////////////////////////////////////////////

	// Nibble doubled into the upper byte, low byte silent
	always_ff @(posedge clk_50 or negedge arst_n) begin
		if (!arst_n) begin
			audio_q <= '0;
			audio_l <= '0;
		end else begin
			audio_q <= audio_in;
			audio_l <= {audio_q, audio_q, {(`CAB_AUDIO_OUT_W - 2*`CAB_AUDIO_IN_W){1'b0}}};
		end
	end

endmodule

//--- src/cab_shell_top.sv
//////////////////////////////////////////////////////////////////////
// Cabinet shell top level
// Host link, decoders and combiner around the tank game core
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "cab_cfg.svh"

module cab_shell_top import cab_pkg::*; (
	input  logic                        clk_50,
	input  logic                        arst_n,
	// Menu processor link
	input  logic                        host_req,
	input  host_op_e                    host_op,
	input  logic [`CAB_HOST_DW-1:0]     host_data,
	output logic                        host_ack,
	input  logic                        download_in,
	// Cabinet side
	input  logic                        rst_in,
	input  logic [`CAB_AUDIO_IN_W-1:0]  audio_in,
	output logic                        core_reset,
	output logic [7:0]                  jb,
	output logic [7:0]                  dsw,
	output logic [11:0]                 video_arx,
	output logic [11:0]                 video_ary,
	output logic                        ce_pix,
	output logic [`CAB_AUDIO_OUT_W-1:0] audio_l
);

	logic [7:0] ctrl_byte;
	logic [1:0] aspect_sel;
	logic       reset_req;

	// Stored words shared by the mapper and the menu decoder
	cab_regs_if regs ();

	host_link u_host_link (
		.clk_50, .arst_n, .host_req, .host_op, .host_data, .download_in,
		.host_ack, .regs(regs.link)
	);

	tread_mapper u_tread_mapper (.clk_50, .arst_n, .regs(regs.mapper), .ctrl_byte);

	menu_decoder u_menu_decoder (
		.clk_50, .arst_n, .regs(regs.menu), .aspect_sel, .dsw, .reset_req
	);

	cabinet_combiner u_cabinet_combiner (
		.clk_50, .arst_n, .rst_in, .ctrl_byte, .aspect_sel, .reset_req, .audio_in,
		.core_reset, .jb, .video_arx, .video_ary, .ce_pix, .audio_l
	);

endmodule

//--- tb/cab_shell_props.sv
//////////////////////////////////////////////////////////////////////
// Handshake and reset properties
// Bound into the host link and the cabinet combiner
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module cab_shell_props (
	input logic       clk_50,
	input logic       arst_n,
	input logic       req,
	input logic       ack,
	input logic       core_reset,
	input logic [7:0] jb
);

	// Ack only answers a synchronized request
	ack_needs_req: assert property (@(posedge clk_50) disable iff (!arst_n)
		$rose(ack) |-> req)
		else $error("host_ack rose without a request");

	// No early release while the host still holds req
	ack_holds: assert property (@(posedge clk_50) disable iff (!arst_n)
		ack && req |=> ack)
		else $error("host_ack dropped while req was high");

	// Controls stay silent during core reset
	jb_quiet: assert property (@(posedge clk_50) disable iff (!arst_n)
		core_reset |-> jb == 8'h00)
		else $error("jb nonzero while core_reset is high");

endmodule

// Link side sees the synchronized req, no reset outputs there
bind host_link cab_shell_props u_link_props (
	.clk_50, .arst_n, .req(req_s), .ack(host_ack), .core_reset(1'b0), .jb(8'h00)
);

// Combiner side has no handshake
bind cabinet_combiner cab_shell_props u_comb_props (
	.clk_50, .arst_n, .req(1'b0), .ack(1'b0), .core_reset, .jb
);

//--- tb/cab_shell_tb.sv
//////////////////////////////////////////////////////////////////////
// Cabinet shell testbench
// Random host transfers checked against a model of the shell
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "cab_cfg.svh"

module cab_shell_tb import cab_pkg::*; ();

	localparam int CYCLE_LIMIT = 20000;

	logic                        clk_50;
	logic                        arst_n;
	logic                        host_req;
	host_op_e                    host_op;
	logic [`CAB_HOST_DW-1:0]     host_data;
	logic                        host_ack;
	logic                        download_in;
	logic                        rst_in;
	logic [`CAB_AUDIO_IN_W-1:0]  audio_in;
	logic                        core_reset;
	logic [7:0]                  jb;
	logic [7:0]                  dsw;
	logic [11:0]                 video_arx;
	logic [11:0]                 video_ary;
	logic                        ce_pix;
	logic [`CAB_AUDIO_OUT_W-1:0] audio_l;

	// Model copies of the stored host words
	logic [`CAB_HOST_DW-1:0] status_m;
	logic [`CAB_HOST_DW-1:0] joy0_m;
	logic [`CAB_HOST_DW-1:0] joy1_m;
	int checks;
	int errors;
	int test_start_errors;
	int cycle_count;

	cab_shell_top DUT (.*);

	always #10 clk_50 = ~clk_50;

	// Watchdog, ends the run once the cycle budget is spent
	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk_50);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("RESULT: FAIL");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Model and checks
	//////////////////////////////////////////////////////////////////////

	// Tread bits left fwd, left back, right fwd, right back
	function automatic logic [3:0] tread_bits(input logic [3:0] dir);
		logic up, down, left, right;
		{up, down, left, right} = dir;
		if (up && !down && !left && !right) return 4'b1010;
		if (up && !down && left && !right)  return 4'b0010;
		if (up && !down && !left && right)  return 4'b1000;
		if (!up && !down && !left && right) return 4'b1001;
		if (!up && down && !left && right)  return 4'b0100;
		if (!up && down && !left && !right) return 4'b0101;
		if (!up && down && left && !right)  return 4'b0001;
		if (!up && !down && left && !right) return 4'b0110;
		// Idle or conflicting directions
		return 4'b0000;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail t=%0t %s expected %0h got %0h", $time, name, exp, act);
		end
	endtask

	task automatic report_test(input string name);
		$display("Test %s done, %0d errors", name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	// Steps in whole cycles, landing 2 ns after the edge
	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk_50);
			#2;
		end
	endtask

	// Outputs from the model words, reset sources and the aspect rule
	task automatic check_outputs();
		logic [15:0] j;
		logic [1:0]  sel;
		logic        rst;
		j   = joy0_m | joy1_m;
		sel = status_m[15:14];
		rst = rst_in | status_m[0] | download_in;
		check_value("core_reset", rst, core_reset);
		check_value("jb", rst ? 8'h00 : {j[7], j[5], j[6], j[4], tread_bits(j[3:0])}, jb);
		check_value("dsw", status_m[13:6], dsw);
		check_value("video_arx", (sel == 2'd0) ? 12'd4 : 12'(sel) - 12'd1, video_arx);
		check_value("video_ary", (sel == 2'd0) ? 12'd3 : 12'd0, video_ary);
	endtask

	// Full four-phase transfer, counting edges for each ack change
	task automatic send_word(input host_op_e op, input logic [15:0] data);
		int n;
		host_op   = op;
		host_data = data;
		host_req  = 1'b1;
		n = 0;
		while (host_ack !== 1'b1 && n < 10) begin
			wait_cycles(1);
			n++;
		end
		if (host_ack !== 1'b1) begin
			errors++;
			$display("Handshake timeout, host_ack never rose at t=%0t", $time);
		end else begin
			check_value("ack_rise_edges", 3, n);
		end
		case (op)
			OP_STATUS: status_m = data;
			OP_JOY0:   joy0_m = data;
			OP_JOY1:   joy1_m = data;
			default:   ;
		endcase
		// Outputs follow the stored word two cycles after ack rises
		wait_cycles(2);
		check_outputs();
		// Host keeps req up a little longer now and then
		wait_cycles($urandom_range(0, 3));
		host_req = 1'b0;
		n = 0;
		while (host_ack !== 1'b0 && n < 10) begin
			wait_cycles(1);
			n++;
		end
		check_value("ack_fall_edges", 3, n);
	endtask

	// Source 0 is rst_in, 1 the menu reset bit, 2 the download flag
	task automatic set_reset_source(input int src, input logic val);
		case (src)
			0:       rst_in = val;
			1:       send_word(OP_STATUS, {status_m[15:1], val});
			default: download_in = val;
		endcase
		wait_cycles(6);
		check_outputs();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [3:0]  order [16];
		logic [3:0]  pick;
		logic [3:0]  tmp;
		logic [15:0] j0;
		logic [15:0] j1;
		logic [15:0] mask;
		logic [7:0]  jb_before;
		logic [3:0]  a;
		logic [3:0]  a_last;
		logic        ce_prev;
		void'($urandom(34));
		clk_50 = 1'b0;
		arst_n = 1'b0;
		host_req = 1'b0;
		host_op = OP_NOP;
		host_data = '0;
		download_in = 1'b0;
		rst_in = 1'b0;
		audio_in = '0;
		status_m = '0;
		joy0_m = '0;
		joy1_m = '0;
		checks = 0;
		errors = 0;
		test_start_errors = 0;
		// Reset values while arst_n is still low
		wait_cycles(5);
		check_value("host_ack", 0, host_ack);
		check_value("core_reset", 1, core_reset);
		check_value("jb", 0, jb);
		check_value("ce_pix", 0, ce_pix);
		arst_n = 1'b1;

		for (int k = 0; k < 40; k++) begin
			send_word(host_op_e'($urandom_range(0, 3)), 16'($urandom));
			check_outputs();
		end
		report_test("handshake");

		// All 16 nibbles in shuffled order, split over both words
		send_word(OP_STATUS, 16'($urandom) & 16'hfffe);
		for (int k = 0; k < 16; k++) order[k] = 4'(k);
		for (int k = 15; k > 0; k--) begin
			pick = 4'($urandom_range(0, k));
			tmp = order[k];
			order[k] = order[pick];
			order[pick] = tmp;
		end
		for (int k = 0; k < 16; k++) begin
			j0 = 16'($urandom);
			j1 = 16'($urandom);
			mask = 16'($urandom);
			j0[3:0] = order[k] & mask[3:0];
			j1[3:0] = order[k] & ~mask[3:0];
			send_word(OP_JOY0, j0);
			check_outputs();
			send_word(OP_JOY1, j1);
			check_outputs();
		end
		report_test("tread_mapping");

		for (int k = 0; k < 20; k++) begin
			send_word(OP_JOY0, 16'($urandom));
			send_word(OP_JOY1, 16'($urandom));
			check_outputs();
			jb_before = jb;
			send_word(OP_NOP, 16'($urandom));
			check_value("jb_after_nop", jb_before, jb);
		end
		report_test("buttons");

		// Every aspect select value, menu reset bit kept clear
		for (int k = 0; k < 24; k++) begin
			j0 = 16'($urandom);
			j0[15:14] = 2'(k);
			j0[0] = 1'b0;
			send_word(OP_STATUS, j0);
			check_outputs();
		end
		report_test("menu_decode");

		// Up and coin give a nonzero control byte to hold off
		send_word(OP_JOY0, 16'h0088);
		send_word(OP_JOY1, 16'h0000);
		check_outputs();
		for (int k = 0; k < 3; k++) begin
			set_reset_source(k, 1'b1);
			check_value("jb_held", 0, jb);
			set_reset_source(k, 1'b0);
		end
		report_test("reset_sources");

		// A new sample every cycle, so audio_l shows the one from two edges back
		a_last = '0;
		for (int k = 0; k < 20; k++) begin
			a = 4'($urandom);
			audio_in = a;
			wait_cycles(1);
			if (k > 0)
				check_value("audio_l", {a_last, a_last, 8'h00}, audio_l);
			a_last = a;
		end
		ce_prev = ce_pix;
		for (int k = 0; k < 20; k++) begin
			wait_cycles(1);
			check_value("ce_pix", !ce_prev, ce_pix);
			ce_prev = ce_pix;
		end
		report_test("audio_pixel");

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- flist.f
+incdir+src
src/cab_pkg.sv
src/cab_regs_if.sv
src/host_link.sv
src/tread_mapper.sv
src/menu_decoder.sv
src/cabinet_combiner.sv
src/cab_shell_top.sv
tb/cab_shell_props.sv
tb/cab_shell_tb.sv

//--- Bender.yml
package:
  name: cab_shell

sources:
  - include_dirs:
      - src
    files:
      - src/cab_pkg.sv
      - src/cab_regs_if.sv
      - src/host_link.sv
      - src/tread_mapper.sv
      - src/menu_decoder.sv
      - src/cabinet_combiner.sv
      - src/cab_shell_top.sv
      - tb/cab_shell_props.sv
      - tb/cab_shell_tb.sv
